// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_kd_tree_search -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "sim passed"

clean:
	rm -rf obj_dir

// File: all.f
kd_types_pkg.sv
kd_cfg_pkg.sv
node_cfg_if.sv
kd_internal_node.sv
kd_tree_level.sv
kd_apb_cfg.sv
kd_tree_search.sv
tb_kd_tree_search.sv

// File: kd_apb_cfg.sv
// Zero wait state slave with misaligned or unmapped accesses flagged through pslverr
`timescale 1ns/10ps
`default_nettype none

module kd_apb_cfg (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire kd_cfg_pkg::apb_addr_t paddr,
  input  wire kd_cfg_pkg::apb_data_t pwdata,
  input  wire logic                  leaf_valid,  // One classified patch per high cycle
  output kd_cfg_pkg::apb_data_t      prdata,
  output logic                       pready,
  output logic                       pslverr,
  node_cfg_if.src                    cfg
);

  logic                  setup;       // First cycle of a transfer
  logic                  access;      // Second cycle where the transfer completes
  kd_cfg_pkg::apb_addr_t node_off;    // Address relative to the node window
  logic                  node_hit;    // Aligned address inside the node window
  logic                  status_hit;
  kd_cfg_pkg::count_t    count_q;     // Classified patches

  assign setup  = psel && !penable;
  assign access = psel && penable;

  assign node_off = paddr - kd_cfg_pkg::node_base;

  // Low bits must be zero and the slot must belong to a real node
  assign node_hit =
    (node_off[$clog2(kd_cfg_pkg::node_stride)-1:0] == '0) &&
    (node_off < kd_cfg_pkg::apb_addr_t'(kd_types_pkg::num_nodes * kd_cfg_pkg::node_stride));

  assign status_hit = (paddr == kd_cfg_pkg::status_addr);

  // Node write goes out in the access cycle and lands on the edge that ends it
  assign cfg.wen    = access && pwrite && node_hit;
  assign cfg.node   = node_off[$clog2(kd_cfg_pkg::node_stride) +: $bits(kd_types_pkg::node_id_t)];
  assign cfg.idx    = pwdata[kd_cfg_pkg::idx_msb:kd_cfg_pkg::idx_lsb];
  assign cfg.median = pwdata[kd_cfg_pkg::median_msb:kd_cfg_pkg::median_lsb];

  assign pready = 1'b1;  // Never stalls

  // Writes must hit a node and reads must hit the status word
  assign pslverr = access && (pwrite ? !node_hit : !status_hit);

  always_comb begin
    if (access && !pwrite && status_hit) begin
      prdata = {{(kd_cfg_pkg::data_width - kd_cfg_pkg::count_width){1'b0}}, count_q};
    end else begin
      prdata = '0;
    end
  end

  // Wraps at the counter width
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (leaf_valid) begin
      count_q <= count_q + 1'b1;
    end
  end

  // An access cycle is always preceded by its setup cycle
  a_apb_phase : assert property (
    @(posedge clk) disable iff (!rst_n)
    penable |-> psel && $past(setup)
  );

endmodule

`default_nettype wire

// File: kd_cfg_pkg.sv
// Register map assumes word aligned node slots and a single read-only status word
`default_nettype none

package kd_cfg_pkg;

  localparam int addr_width = 8;   // APB byte address
  localparam int data_width = 32;  // APB data bus

  typedef logic [addr_width-1:0] apb_addr_t;
  typedef logic [data_width-1:0] apb_data_t;

  // Node n configuration lives at node_base + n * node_stride
  localparam apb_addr_t node_base   = 8'h00;
  localparam int        node_stride = 4;
  localparam apb_addr_t status_addr = 8'h20;  // Classified patch counter

  // Configuration word layout
  localparam int idx_lsb    = 0;
  localparam int idx_msb    = 2;   // Three index bits
  localparam int median_lsb = 11;
  localparam int median_msb = 21;  // Full 11-bit signed median

  // Counter wraps silently at its width
  localparam int count_width = 16;
  typedef logic [count_width-1:0] count_t;

endpackage

`default_nettype wire

// File: kd_internal_node.sv
// Decision is combinational from the patch and an index of 5 or more slices a zero value
`timescale 1ns/10ps
`default_nettype none

module kd_internal_node (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   wen,         // Load strobe for this node only
  input  wire kd_types_pkg::dim_idx_t cfg_idx,
  input  wire kd_types_pkg::median_t  cfg_median,
  input  wire kd_types_pkg::patch_t   patch,
  output logic                        go_left      // High when the slice is below the median
);

  kd_types_pkg::dim_idx_t idx_q;     // Stored dimension index
  kd_types_pkg::median_t  median_q;  // Stored signed median
  kd_types_pkg::dim_t     dims [kd_types_pkg::num_dims];
  kd_types_pkg::dim_t     slice;     // Dimension picked out of the patch

  // Configuration registers keep their value until the next write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx_q    <= kd_types_pkg::idx_invalid;  // Unconfigured node
      median_q <= '0;
    end else if (wen) begin
      idx_q    <= cfg_idx;
      median_q <= cfg_median;
    end
  end

  // Split the packed patch into dimensions with dimension 0 from the top bits
  for (genvar d = 0; d < kd_types_pkg::num_dims; d++) begin : g_dim
    assign dims[d] = patch[(kd_types_pkg::num_dims - d) * kd_types_pkg::dim_width - 1
                           -: kd_types_pkg::dim_width];
  end

  always_comb begin
    if (idx_q < kd_types_pkg::dim_idx_t'(kd_types_pkg::num_dims)) begin
      slice = dims[idx_q];
    end else begin
      slice = '0;  // Invalid index reads as zero so the patch goes right
    end
  end

  assign go_left = slice < median_q;  // Both operands are signed

  // Only real dimensions or the disable value may be written
  a_cfg_idx_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    wen |-> (cfg_idx < kd_types_pkg::dim_idx_t'(kd_types_pkg::num_dims)) ||
            (cfg_idx == kd_types_pkg::idx_invalid)
  );

endmodule

`default_nettype wire

// File: kd_search_vectors.txt
# Each line is W addr wdata pslverr or R addr prdata pslverr or P d0 d1 d2 d3 d4 leaf or D to drain
# All fields are hex and patch dimensions are 11-bit two's complement with dimension 0 first
R 20 00000000 0
P 7fb 032 000 003 000 7
P 000 7ff 7cd 7fe 000 7
P 400 3ff 000 000 000 7
D
W 00 00000000 0
W 04 00032001 0
W 08 003e7002 0
W 0c 00005003 0
W 10 00000004 0
W 14 003ff803 0
W 18 00064000 0
P 7fb 032 000 003 000 0
P 7ff 00a 000 00a 000 1
P 79c 064 000 000 7f9 2
P 400 3ff 000 000 000 3
P 000 000 7cd 7fe 000 4
P 005 000 738 7ff 000 5
P 0c7 000 7ce 000 000 6
P 0c8 000 3ff 000 000 7
D
W 20 12345678 1
W 1c 00000001 1
W 06 00000000 1
R 04 00000000 1
R 20 0000000b 0
P 000 000 7cd 7fe 000 4
P 79c 064 000 000 7f9 2
D
W 00 00000001 0
P 7fb 032 000 003 000 6
P 000 7ff 7cd 7fe 000 0
D

// File: kd_tree_level.sv
// At level 0 in_path is a single tie-off bit that the root ignores since it has one node
`timescale 1ns/10ps
`default_nettype none

module kd_tree_level #(
  parameter int level = 0  // 0 is the root level
) (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  node_cfg_if.dst                                 cfg,
  input  wire logic                               in_valid,
  input  wire kd_types_pkg::patch_t               in_patch,
  input  wire logic [((level == 0) ? 1 : level)-1:0] in_path,   // Decisions of earlier levels
  output logic                                    out_valid,
  output kd_types_pkg::patch_t                    out_patch,
  output logic [level:0]                          out_path
);

  localparam int nodes = 1 << level;  // Nodes on this level
  localparam int base  = nodes - 1;   // Heap number of the leftmost node

  logic [nodes-1:0] node_wen;  // Per node write strobe
  logic [nodes-1:0] go_left;   // Decision of every node on the level
  logic             sel_left;  // Decision of the node on this patch's path
  int               node_sel;
  logic [level:0]   path_d;    // Path extended by this level

  // The partial path names the node within the level
  assign node_sel = (level == 0) ? 0 : int'(in_path);

  for (genvar k = 0; k < nodes; k++) begin : g_node
    assign node_wen[k] = cfg.wen && (cfg.node == kd_types_pkg::node_id_t'(base + k));

    kd_internal_node node_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .wen        (node_wen[k]),
      .cfg_idx    (cfg.idx),
      .cfg_median (cfg.median),
      .patch      (in_patch),
      .go_left    (go_left[k])
    );
  end

  always_comb begin
    sel_left = 1'b0;
    for (int k = 0; k < nodes; k++) begin
      if (node_sel == k) sel_left = go_left[k];
    end
  end

  // Right is recorded as 1 so the final path equals the leaf number
  if (level == 0) begin : g_root_path
    assign path_d = ~sel_left;
  end else begin : g_path
    assign path_d = {in_path, ~sel_left};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) out_valid <= 1'b0;
    else        out_valid <= in_valid;
  end

  // Payload follows valid without a reset
  always_ff @(posedge clk) begin
    out_patch <= in_patch;
    out_path  <= path_d;
  end

  a_valid_known : assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid));

endmodule

`default_nettype wire

// File: kd_tree_search.sv
// Fixed-rate pipeline without back-pressure so each leaf must be taken in the cycle it shows
`timescale 1ns/10ps
`default_nettype none

module kd_tree_search (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire kd_cfg_pkg::apb_addr_t paddr,
  input  wire kd_cfg_pkg::apb_data_t pwdata,
  output kd_cfg_pkg::apb_data_t      prdata,
  output logic                       pready,
  output logic                       pslverr,
  input  wire logic                  patch_valid,  // Accepted on every edge where high
  input  wire kd_types_pkg::patch_t  patch,
  output logic                       leaf_valid,   // Three cycles after the patch
  output kd_types_pkg::leaf_t        leaf
);

  node_cfg_if cfg_bus ();  // Shared by all levels

  logic                 valid_1;  // Root stage output
  kd_types_pkg::patch_t patch_1;
  logic [0:0]           path_1;
  logic                 valid_2;  // Middle stage output
  kd_types_pkg::patch_t patch_2;
  logic [1:0]           path_2;

  kd_apb_cfg apb_cfg_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .leaf_valid (leaf_valid),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .cfg        (cfg_bus.src)
  );

  // The root has a single node and needs no path
  kd_tree_level #(.level(0)) level_0_inst (
    .clk (clk), .rst_n (rst_n), .cfg (cfg_bus.dst),
    .in_valid (patch_valid), .in_patch (patch), .in_path (1'b0),
    .out_valid (valid_1), .out_patch (patch_1), .out_path (path_1)
  );

  kd_tree_level #(.level(1)) level_1_inst (
    .clk (clk), .rst_n (rst_n), .cfg (cfg_bus.dst),
    .in_valid (valid_1), .in_patch (patch_1), .in_path (path_1),
    .out_valid (valid_2), .out_patch (patch_2), .out_path (path_2)
  );

  // The full path of the last level is the leaf number and no level follows to take the patch
  kd_tree_level #(.level(2)) level_2_inst (
    .clk (clk), .rst_n (rst_n), .cfg (cfg_bus.dst),
    .in_valid (valid_2), .in_patch (patch_2), .in_path (path_2),
    .out_valid (leaf_valid), .out_patch (), .out_path (leaf)
  );

endmodule

`default_nettype wire

// File: kd_types_pkg.sv
// Tree shape is fixed at three levels over five signed 11-bit dimensions with no override
`default_nettype none

package kd_types_pkg;

  localparam int num_dims    = 5;                      // Dimensions in every patch
  localparam int dim_width   = 11;                     // Each dimension is a signed value
  localparam int patch_width = num_dims * dim_width;   // 55 bits on the wire
  localparam int tree_depth  = 3;                      // One pipeline stage per level
  localparam int num_nodes   = (1 << tree_depth) - 1;  // Internal nodes in heap order
  localparam int num_leaves  = 1 << tree_depth;

  // Dimension 0 occupies the top bits of the packed patch
  typedef logic [patch_width-1:0] patch_t;

  typedef logic signed [dim_width-1:0] dim_t;     // One sliced dimension
  typedef logic signed [dim_width-1:0] median_t;  // Split value of a node

  // Three bits cover the five dimensions and leave 5 to 7 unused
  typedef logic [2:0] dim_idx_t;

  // Root is node 0 and level L node k is 2^L-1+k
  typedef logic [$clog2(num_nodes)-1:0] node_id_t;

  // The root decision lands in the MSB and a set bit means the patch went right
  typedef logic [$clog2(num_leaves)-1:0] leaf_t;

  // Index held by a node that software never wrote
  localparam dim_idx_t idx_invalid = 3'b111;

endpackage

`default_nettype wire

// File: node_cfg_if.sv
// Fields are only meaningful in the cycle wen is high and there is no handshake back
`timescale 1ns/10ps
`default_nettype none

interface node_cfg_if;

  logic                   wen;     // One-cycle strobe per accepted APB write
  kd_types_pkg::node_id_t node;    // Heap-order number of the target node
  kd_types_pkg::dim_idx_t idx;     // Dimension the node will slice
  kd_types_pkg::median_t  median;  // Signed split value

  // The APB block decodes the bus and produces the write
  modport src (
    output wen, node, idx, median
  );

  // Every tree level listens and picks out its own nodes
  modport dst (
    input wen, node, idx, median
  );

endinterface

`default_nettype wire

// File: tb_kd_tree_search.sv
// Vector file gives stimulus and expected leaves and the LFSR burst runs on the final tree
`timescale 1ns/10ps
`default_nettype none

module tb_kd_tree_search;

  localparam int timeout_cycles = 64;  // Longest any single wait may take

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  kd_cfg_pkg::apb_addr_t paddr;
  kd_cfg_pkg::apb_data_t pwdata;
  kd_cfg_pkg::apb_data_t prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  patch_valid;
  kd_types_pkg::patch_t  patch;
  logic                  leaf_valid;
  kd_types_pkg::leaf_t   leaf;

  kd_types_pkg::dim_idx_t model_idx [kd_types_pkg::num_nodes];  // Tree as written over APB
  kd_types_pkg::median_t  model_median [kd_types_pkg::num_nodes];
  kd_types_pkg::leaf_t    exp_leaf_q [$];       // Outstanding patches in send order
  int                     exp_due_q [$];        // Cycle on which each leaf must show
  logic [31:0]            lfsr = 32'h5d2da281;
  int                     cyc = 0;              // Rising edges seen so far
  int                     patches_sent = 0;
  int                     leaf_errors = 0;      // Wrong leaf values
  int                     order_errors = 0;     // Late, stray or missing results
  int                     apb_errors = 0;
  int                     misc_errors = 0;      // Timeouts and vector file trouble

  kd_tree_search kd_tree_search_inst (
    .clk (clk), .rst_n (rst_n), .psel (psel), .penable (penable), .pwrite (pwrite),
    .paddr (paddr), .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .patch_valid (patch_valid), .patch (patch), .leaf_valid (leaf_valid), .leaf (leaf)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_leaf(input kd_types_pkg::leaf_t got, input kd_types_pkg::leaf_t exp);
    if (got !== exp) begin
      $display("FAIL leaf got %h expected %h at cycle %0d", got, exp, cyc);
      leaf_errors++;
    end
  endtask

  task automatic check_data(input kd_cfg_pkg::apb_data_t got, input kd_cfg_pkg::apb_data_t exp);
    if (got !== exp) begin
      $display("FAIL prdata got %h expected %h", got, exp);
      apb_errors++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL pslverr got %h expected %h", got, exp);
      apb_errors++;
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic kd_types_pkg::patch_t random_patch();
    kd_types_pkg::patch_t p;
    for (int b = 0; b < kd_types_pkg::patch_width; b++) p[b] = lfsr_bit();
    return p;
  endfunction

  // Walks the heap from the root where the children of node n are 2n+1 and 2n+2
  function automatic kd_types_pkg::leaf_t predict_leaf(input kd_types_pkg::patch_t p);
    int                  node;
    int                  sel;
    kd_types_pkg::dim_t  value;
    kd_types_pkg::leaf_t path;
    logic                right;
    node = 0;
    path = '0;
    for (int lvl = 0; lvl < kd_types_pkg::tree_depth; lvl++) begin
      sel   = int'(model_idx[node]);
      value = '0;  // Unknown dimension reads as zero
      if (sel < kd_types_pkg::num_dims) begin
        value = p[(kd_types_pkg::num_dims - 1 - sel) * kd_types_pkg::dim_width
                  +: kd_types_pkg::dim_width];
      end
      right = !(value < model_median[node]);  // Ties go right
      path  = {path[1:0], right};
      node  = 2 * node + 1 + int'(right);
    end
    return path;
  endfunction

  task automatic advance_cycle();
    @(posedge clk);
    #1;  // Inputs change just after the edge
  endtask

  task automatic send_patch(input kd_types_pkg::patch_t p, input kd_types_pkg::leaf_t exp);
    advance_cycle();
    patch_valid = 1'b1;
    patch       = p;
    exp_leaf_q.push_back(exp);
    exp_due_q.push_back(cyc + kd_types_pkg::tree_depth);  // Accepted on the next edge
    patches_sent++;
  endtask

  task automatic drain();
    int waited;
    advance_cycle();
    patch_valid = 1'b0;
    waited      = 0;
    while (exp_leaf_q.size() != 0 && waited < timeout_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (exp_leaf_q.size() != 0) begin
      $display("Pipeline still held %0d patches after the drain timeout", exp_leaf_q.size());
      misc_errors++;
    end
  endtask

  task automatic apb_transfer(input kd_cfg_pkg::apb_addr_t addr, input logic write,
                              input kd_cfg_pkg::apb_data_t data,
                              output kd_cfg_pkg::apb_data_t rdata, output logic err);
    int waited;
    advance_cycle();
    patch_valid = 1'b0;
    psel        = 1'b1;  // Setup cycle
    penable     = 1'b0;
    pwrite      = write;
    paddr       = addr;
    pwdata      = data;
    advance_cycle();
    penable = 1'b1;      // Access cycle
    waited  = 0;
    do begin
      @(negedge clk);    // Sample mid cycle where the slave outputs are settled
      waited++;
    end while (pready !== 1'b1 && waited < timeout_cycles);
    if (pready !== 1'b1) begin
      $display("APB transfer to address %h never saw pready", addr);
      misc_errors++;
    end
    rdata = prdata;
    err   = pslverr;
    advance_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Results must come in send order exactly on their due cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (leaf_valid && exp_leaf_q.size() == 0) begin
        $display("leaf_valid rose at cycle %0d with no patch outstanding", cyc);
        order_errors++;
      end else if (leaf_valid) begin
        if (exp_due_q[0] != cyc) begin
          $display("Leaf came at cycle %0d but was due at cycle %0d", cyc, exp_due_q[0]);
          order_errors++;
        end
        check_leaf(leaf, exp_leaf_q.pop_front());
        void'(exp_due_q.pop_front());
      end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cyc) begin
        $display("No leaf_valid for the patch due at cycle %0d", exp_due_q[0]);
        order_errors++;
        void'(exp_due_q.pop_front());
        void'(exp_leaf_q.pop_front());
      end
    end
  end

  initial begin
    int                    fd;
    int                    c;
    int                    n;
    int                    slot;
    kd_cfg_pkg::apb_addr_t addr;
    kd_cfg_pkg::apb_data_t data;
    kd_cfg_pkg::apb_data_t rdata;
    logic                  err;
    logic                  exp_err;
    kd_types_pkg::dim_t    d0;
    kd_types_pkg::dim_t    d1;
    kd_types_pkg::dim_t    d2;
    kd_types_pkg::dim_t    d3;
    kd_types_pkg::dim_t    d4;
    kd_types_pkg::leaf_t   exp_leaf;
    kd_types_pkg::patch_t  p;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    patch_valid = 1'b0;
    patch       = '0;
    for (int k = 0; k < kd_types_pkg::num_nodes; k++) begin
      model_idx[k]    = kd_types_pkg::idx_invalid;  // Reset state of every node
      model_median[k] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    fd = $fopen("kd_search_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open kd_search_vectors.txt for reading");
      misc_errors++;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          while (c != -1 && c != "\n") c = $fgetc(fd);  // Skip a comment line
        end else if (c == "W") begin
          n = $fscanf(fd, "%h %h %h", addr, data, exp_err);
          if (n != 3) begin
            $display("A write line in the vector file lacks some of its fields");
            misc_errors++;
          end
          apb_transfer(addr, 1'b1, data, rdata, err);
          check_err(err, exp_err);
          slot = int'(addr - kd_cfg_pkg::node_base);
          // A node slot is word aligned and below the last node
          if (slot % kd_cfg_pkg::node_stride == 0 &&
              slot < kd_cfg_pkg::node_stride * kd_types_pkg::num_nodes) begin
            model_idx[slot / kd_cfg_pkg::node_stride] =
              data[kd_cfg_pkg::idx_msb:kd_cfg_pkg::idx_lsb];
            model_median[slot / kd_cfg_pkg::node_stride] =
              data[kd_cfg_pkg::median_msb:kd_cfg_pkg::median_lsb];
          end
        end else if (c == "R") begin
          n = $fscanf(fd, "%h %h %h", addr, data, exp_err);
          if (n != 3) begin
            $display("A read line in the vector file lacks some of its fields");
            misc_errors++;
          end
          apb_transfer(addr, 1'b0, '0, rdata, err);
          check_data(rdata, data);
          check_err(err, exp_err);
        end else if (c == "P") begin
          n = $fscanf(fd, "%h %h %h %h %h %h", d0, d1, d2, d3, d4, exp_leaf);
          if (n != 6) begin
            $display("A patch line in the vector file lacks some of its fields");
            misc_errors++;
          end
          send_patch({d0, d1, d2, d3, d4}, exp_leaf);
        end else if (c == "D") begin
          drain();
        end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
          $display("Vector file holds an unknown command character %0d", c);
          misc_errors++;
        end
        if (c != -1) c = $fgetc(fd);
      end
      $fclose(fd);
    end

    // Back-to-back burst checked against the model of the tree as last written
    for (int k = 0; k < 64; k++) begin
      p = random_patch();
      send_patch(p, predict_leaf(p));
    end
    drain();
    apb_transfer(kd_cfg_pkg::status_addr, 1'b0, '0, rdata, err);
    check_data(rdata, kd_cfg_pkg::apb_data_t'(patches_sent % (1 << kd_cfg_pkg::count_width)));
    check_err(err, 1'b0);

    $display("errors leaf %0d order %0d apb %0d other %0d",
             leaf_errors, order_errors, apb_errors, misc_errors);
    if (leaf_errors + order_errors + apb_errors + misc_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
